// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [15:0] cinstr_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  reg_t;

  // major opcodes of the 32-bit forms
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] FUNCT3_ADD = 3'b000; // shared by ADD and ADDI
  localparam logic [6:0] FUNCT7_ADD = 7'b0000000;

  localparam reg_t REG_ZERO = 5'd0;

  // compressed quadrants, low two bits of a 16-bit word
  localparam logic [1:0] C_Q1 = 2'b01;
  localparam logic [1:0] C_Q2 = 2'b10;
  localparam logic [1:0] C_FULL = 2'b11; // not compressed

  // quadrant 1 funct3
  localparam logic [2:0] C3_ADDI = 3'b000;
  localparam logic [2:0] C3_LI   = 3'b010;
  localparam logic [2:0] C3_J    = 3'b101;

  // quadrant 2 funct4
  localparam logic [3:0] C4_MV  = 4'b1000;
  localparam logic [3:0] C4_ADD = 4'b1001;

endpackage

// File: src/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

  // program memory
  localparam int MEM_BYTES = 256;
  localparam int MEM_AW    = 8;

  // buffer depths, also the initial credit counts of the two links
  localparam int QUEUE_DEPTH = 4;
  localparam int ISSUE_DEPTH = 2;

  localparam int CREDIT_W = 3;

  typedef logic [CREDIT_W-1:0] credit_t;
  typedef logic [MEM_AW-1:0]   mem_idx_t;

endpackage

// File: src/fetch_if.sv
interface fetch_if
  import rv_isa_pkg::*;
();

  logic   valid;  // push strobe
  addr_t  pc;
  instr_t instr;
  logic   credit; // one credit back per pulse

  modport producer (
    output valid,
    output pc,
    output instr,
    input  credit
  );

  modport consumer (
    input  valid,
    input  pc,
    input  instr,
    output credit
  );

endinterface

// File: src/flash_loader.sv
module flash_loader
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     flash,
  input  logic     uart_valid,
  input  byte_t    uart_data,
  output logic     wr_en,
  output mem_idx_t wr_addr,
  output byte_t    wr_data,
  output logic     clear
);

  typedef enum logic {
    CLEAR,
    WRITE
  } load_state_t;

  load_state_t state;
  mem_idx_t    addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CLEAR;
      addr  <= '0;
    end else if (!flash) begin
      state <= CLEAR; // next flash starts clean at address 0
      addr  <= '0;
    end else begin
      case (state)
        CLEAR: state <= WRITE;
        WRITE: begin
          if (uart_valid) begin
            addr <= addr + 1'b1;
          end
        end
        default: state <= CLEAR;
      endcase
    end
  end

  assign clear   = flash && (state == CLEAR);
  assign wr_en   = flash && (state == WRITE) && uart_valid;
  assign wr_addr = addr;
  assign wr_data = uart_data;

  // a byte in the clear cycle would be dropped
  a_no_write_during_clear: assert property (
    @(posedge clk) disable iff (rst) clear |-> !uart_valid
  );

endmodule

// File: src/program_memory.sv
module program_memory
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     wr_en,
  input  mem_idx_t wr_addr,
  input  byte_t    wr_data,
  input  logic     clear,
  input  addr_t    rd_addr,
  output instr_t   rd_instr
);

  byte_t mem [MEM_BYTES];

  mem_idx_t idx0;
  mem_idx_t idx1;
  mem_idx_t idx2;
  mem_idx_t idx3;

  always_ff @(posedge clk) begin
    if (clear) begin
      for (int i = 0; i < MEM_BYTES; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // byte indices wrap around the end of memory
  assign idx0 = rd_addr[MEM_AW-1:0];
  assign idx1 = idx0 + mem_idx_t'(1);
  assign idx2 = idx0 + mem_idx_t'(2);
  assign idx3 = idx0 + mem_idx_t'(3);

  // little endian
  assign rd_instr = {mem[idx3], mem[idx2], mem[idx1], mem[idx0]};

endmodule

// File: src/rvc_expander.sv
module rvc_expander
  import rv_isa_pkg::*;
(
  input  cinstr_t cinstr,
  output instr_t  instr
);

  reg_t        rd;
  reg_t        rs2;
  logic [2:0]  funct3;
  logic [3:0]  funct4;
  logic [11:0] imm6;  // CI immediate, sign extended to 12 bits
  logic [20:0] j_off; // CJ offset, sign extended, bit 0 zero

  assign rd     = cinstr[11:7];
  assign rs2    = cinstr[6:2];
  assign funct3 = cinstr[15:13];
  assign funct4 = cinstr[15:12];

  assign imm6 = {{6{cinstr[12]}}, cinstr[12], cinstr[6:2]};

  // offset[11|4|9:8|10|6|7|3:1|5] sits in bits 12:2
  assign j_off = {
    {10{cinstr[12]}}, // bits 20..11
    cinstr[8],        // 10
    cinstr[10:9],     // 9:8
    cinstr[6],        // 7
    cinstr[7],        // 6
    cinstr[2],        // 5
    cinstr[11],       // 4
    cinstr[5:3],      // 3:1
    1'b0
  };

  always_comb begin
    instr = '0; // illegal unless matched below
    case (cinstr[1:0])
      C_Q1: begin
        case (funct3)
          C3_ADDI: instr = {imm6, rd, FUNCT3_ADD, rd, OPC_OP_IMM};
          C3_LI:   instr = {imm6, REG_ZERO, FUNCT3_ADD, rd, OPC_OP_IMM};
          C3_J: begin
            instr = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                     REG_ZERO, OPC_JAL};
          end
          default: instr = '0;
        endcase
      end
      C_Q2: begin
        // rs2 of zero selects C.JR / C.JALR / C.EBREAK, not handled
        if (rs2 != REG_ZERO) begin
          case (funct4)
            C4_MV:   instr = {FUNCT7_ADD, rs2, REG_ZERO, FUNCT3_ADD, rd, OPC_OP};
            C4_ADD:  instr = {FUNCT7_ADD, rs2, rd, FUNCT3_ADD, rd, OPC_OP};
            default: instr = '0;
          endcase
        end
      end
      default: instr = '0;
    endcase
  end

endmodule

// File: src/fetch_unit.sv
module fetch_unit
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    flash,
  input  logic    redirect,
  input  addr_t   redirect_pc,
  input  instr_t  rd_instr,
  output addr_t   rd_addr,
  fetch_if.producer q
);

  addr_t   pc;
  addr_t   pc_next;
  credit_t credits;
  instr_t  expanded;
  logic    is_compressed;
  logic    push;

  rvc_expander u_rvc_expander (
    .cinstr (rd_instr[15:0]),
    .instr  (expanded)
  );

  assign rd_addr       = pc;
  assign is_compressed = (rd_instr[1:0] != C_FULL);
  assign push          = (credits != '0) && !flash && !redirect;

  assign q.valid = push;
  assign q.pc    = pc;
  assign q.instr = is_compressed ? expanded : rd_instr;

  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (flash) begin
      pc_next = '0;
    end else if (!push) begin
      pc_next = pc; // out of credits, hold
    end else if (is_compressed) begin
      pc_next = pc + 32'd2;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= '0;
      credits <= credit_t'(QUEUE_DEPTH);
    end else begin
      pc <= pc_next;
      if (redirect) begin
        credits <= credit_t'(QUEUE_DEPTH); // queue empties on the same edge
      end else begin
        credits <= credits + credit_t'(q.credit) - credit_t'(push);
      end
    end
  end

  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) credits <= credit_t'(QUEUE_DEPTH)
  );

endmodule

// File: src/instr_queue.sv
module instr_queue
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic redirect,
  fetch_if.consumer in,
  fetch_if.producer out
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  addr_t  pc_mem    [QUEUE_DEPTH];
  instr_t instr_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  credit_t          out_credits; // free slots in the issue port

  logic push;
  logic pop;

  assign push = in.valid && !redirect;
  assign pop  = (count != '0) && (out_credits != '0) && !redirect;

  assign out.valid = pop;
  assign out.pc    = pc_mem[rd_ptr];
  assign out.instr = instr_mem[rd_ptr];
  assign in.credit = pop; // slot freed upstream with the pop

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]    <= in.pc;
      instr_mem[wr_ptr] <= in.instr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      out_credits <= credit_t'(ISSUE_DEPTH);
    end else begin
      wr_ptr      <= wr_ptr + PTR_W'(push);
      rd_ptr      <= rd_ptr + PTR_W'(pop);
      count       <= count + CNT_W'(push) - CNT_W'(pop);
      out_credits <= out_credits + credit_t'(out.credit) - credit_t'(pop);
    end
  end

  // the fetch unit credits must keep pushes away from a full queue
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (rst) in.valid |-> count != CNT_W'(QUEUE_DEPTH)
  );

  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) out_credits <= credit_t'(ISSUE_DEPTH)
  );

endmodule

// File: src/issue_port.sv
module issue_port
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   redirect,
  input  logic   out_ready,
  fetch_if.consumer in,
  output logic   out_valid,
  output addr_t  out_pc,
  output instr_t out_instr
);

  localparam int PTR_W = $clog2(ISSUE_DEPTH);
  localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);

  addr_t  pc_buf    [ISSUE_DEPTH];
  instr_t instr_buf [ISSUE_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;

  logic push;
  logic accept;

  assign push   = in.valid && !redirect;
  assign accept = out_valid && out_ready;

  assign out_valid = (count != '0);
  assign out_pc    = pc_buf[head]; // oldest entry
  assign out_instr = instr_buf[head];
  assign in.credit = accept && !redirect;

  always_ff @(posedge clk) begin
    if (push) begin
      pc_buf[tail]    <= in.pc;
      instr_buf[tail] <= in.instr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + PTR_W'(accept);
      tail  <= tail + PTR_W'(push);
      count <= count + CNT_W'(push) - CNT_W'(accept);
    end
  end

  // queue credits must never overrun the two holding slots
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (rst) in.valid |-> count != CNT_W'(ISSUE_DEPTH)
  );

endmodule

// File: src/fetch_top.sv
module fetch_top
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   flash,
  input  logic   uart_valid,
  input  byte_t  uart_data,
  input  logic   redirect,
  input  addr_t  redirect_pc,
  input  logic   out_ready,
  output logic   out_valid,
  output addr_t  out_pc,
  output instr_t out_instr
);

  logic     wr_en;
  mem_idx_t wr_addr;
  byte_t    wr_data;
  logic     clear;
  addr_t    rd_addr;
  instr_t   rd_instr;

  fetch_if fetch_q ();
  fetch_if q_issue ();

  flash_loader u_flash_loader (
    .clk        (clk),
    .rst        (rst),
    .flash      (flash),
    .uart_valid (uart_valid),
    .uart_data  (uart_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .clear      (clear)
  );

  program_memory u_program_memory (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .clear    (clear),
    .rd_addr  (rd_addr),
    .rd_instr (rd_instr)
  );

  fetch_unit u_fetch_unit (
    .clk         (clk),
    .rst         (rst),
    .flash       (flash),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .rd_instr    (rd_instr),
    .rd_addr     (rd_addr),
    .q           (fetch_q.producer)
  );

  instr_queue u_instr_queue (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .in       (fetch_q.consumer),
    .out      (q_issue.producer)
  );

  issue_port u_issue_port (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .out_ready (out_ready),
    .in        (q_issue.consumer),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_instr (out_instr)
  );

endmodule

// File: dv/fetch_checks.svh
`ifndef FETCH_CHECKS_SVH
`define FETCH_CHECKS_SVH

task automatic check_pc(input string name, input addr_t got, input addr_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  end
endtask

task automatic check_instr(input string name, input instr_t got, input instr_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    $display("Simulation failed");
    $fatal(1);
  end
endtask

// reference expansion, straight from the C extension encodings
function automatic instr_t expand_ref(input cinstr_t c);
  logic [11:0] imm;
  logic [20:0] off;
  reg_t        rd;
  reg_t        rs2;
  instr_t      res;
  rd  = c[11:7];
  rs2 = c[6:2];
  imm = 12'($signed({c[12], c[6:2]}));
  off = 21'($signed({c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0}));
  res = '0; // anything unsupported is illegal
  if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
    res = {imm, rd, 3'b000, rd, OPC_OP_IMM};
  end else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
    res = {imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
  end else if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
    res = {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
  end else if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && rs2 != 5'd0) begin
    res = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
  end else if (c[1:0] == 2'b10 && c[15:12] == 4'b1001 && rs2 != 5'd0) begin
    res = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
  end
  return res;
endfunction

// little endian word from the image, wrapping like the memory
function automatic instr_t word_at(input addr_t pc);
  mem_idx_t idx;
  instr_t   w;
  idx = pc[MEM_AW-1:0];
  for (int k = 0; k < 4; k++) begin
    w[8*k +: 8] = image[mem_idx_t'(idx + k)];
  end
  return w;
endfunction

function automatic instr_t model_instr(input addr_t pc);
  instr_t w;
  w = word_at(pc);
  return (w[1:0] == 2'b11) ? w : expand_ref(w[15:0]);
endfunction

function automatic addr_t model_next_pc(input addr_t pc);
  instr_t w;
  w = word_at(pc);
  return (w[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
endfunction

task automatic send_byte(input byte_t b);
  @(posedge clk);
  uart_valid <= 1'b1;
  uart_data  <= b;
endtask

`endif

// File: dv/tb_fetch_top.sv
module tb_fetch_top
  import rv_isa_pkg::*;
  import fetch_cfg_pkg::*;
();

  localparam int STALL_FACTOR  = 8;
  localparam int TOTAL_ENTRIES = 8 + 9 + 16 + 12 + 8;
  localparam int FLASH_CYCLES  = 5 * 64; // generous per image
  localparam int WATCHDOG_CYCLES = TOTAL_ENTRIES * STALL_FACTOR + FLASH_CYCLES + 200;

  logic   clk;
  logic   rst;
  logic   flash;
  logic   uart_valid;
  byte_t  uart_data;
  logic   redirect;
  addr_t  redirect_pc;
  logic   out_ready;
  logic   out_valid;
  addr_t  out_pc;
  instr_t out_instr;

  byte_t image [MEM_BYTES]; // what the model expects in memory
  int    image_len;
  addr_t model_pc;

  `include "fetch_checks.svh"

  fetch_top DUT (
    .clk         (clk),
    .rst         (rst),
    .flash       (flash),
    .uart_valid  (uart_valid),
    .uart_data   (uart_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_pc      (out_pc),
    .out_instr   (out_instr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within the cycle budget");
    $display("Simulation failed");
    $fatal(1);
  end

  function automatic cinstr_t encode_c_li(input reg_t rd, input logic [5:0] imm);
    return {3'b010, imm[5], rd, imm[4:0], 2'b01};
  endfunction

  task automatic clear_image();
    for (int i = 0; i < MEM_BYTES; i++) begin
      image[i] = '0;
    end
    image_len = 0;
  endtask

  task automatic put_word(input instr_t w);
    for (int k = 0; k < 4; k++) begin
      image[image_len + k] = w[8*k +: 8];
    end
    image_len += 4;
  endtask

  task automatic put_half(input cinstr_t h);
    image[image_len]     = h[7:0];
    image[image_len + 1] = h[15:8];
    image_len += 2;
  endtask

  // every third entry full width, the rest C.LI
  task automatic build_mixed_stream(input int n);
    for (int i = 0; i < n; i++) begin
      if (i % 3 == 0) begin
        put_word({12'(i + 100), 5'd3, 3'b000, 5'(i % 31 + 1), OPC_OP_IMM});
      end else begin
        put_half(encode_c_li(5'(i % 31 + 1), 6'(i)));
      end
    end
  endtask

  // redirect flushes stale entries, then the loader clears and writes
  task automatic flash_image();
    @(posedge clk);
    flash       <= 1'b1;
    redirect    <= 1'b1;
    redirect_pc <= '0;
    out_ready   <= 1'b0;
    @(posedge clk);
    redirect <= 1'b0;
    for (int i = 0; i < image_len; i++) begin
      send_byte(image[i]);
    end
    @(posedge clk);
    uart_valid <= 1'b0;
    flash      <= 1'b0;
    model_pc = '0;
  endtask

  task automatic collect_and_check(input int count, input int ready_pct);
    int got;
    got = 0;
    while (got < count) begin
      @(posedge clk);
      out_ready <= ($urandom_range(99) < ready_pct);
      @(negedge clk);
      if (out_valid && out_ready) begin // taken at the next edge
        check_pc("out_pc", out_pc, model_pc);
        check_instr("out_instr", out_instr, model_instr(model_pc));
        model_pc = model_next_pc(model_pc);
        got++;
      end
    end
  endtask

  task automatic test_plain_program();
    clear_image();
    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) begin
        put_word({12'(i * 3 + 1), 5'd0, 3'b000, 5'(i + 1), OPC_OP_IMM});
      end else begin
        put_word({7'd0, 5'(i), 5'(i + 2), 3'b000, 5'(i + 4), OPC_OP});
      end
    end
    flash_image();
    collect_and_check(8, 100);
  endtask

  task automatic test_compressed_mix();
    clear_image();
    put_half(16'h12F5); // c.addi x5, -3
    put_half(16'h451D); // c.li x10, 7
    put_half(16'h8426); // c.mv x8, x9
    put_half(16'h9426); // c.add x8, x9
    put_word(32'h00500113);
    put_half(16'hA8A1); // c.j
    put_half(16'h4398); // c.lw, not supported
    put_half(16'hBFDD); // c.j backwards
    flash_image();
    collect_and_check(9, 100);
  endtask

  task automatic test_back_pressure();
    clear_image();
    build_mixed_stream(16);
    flash_image();
    collect_and_check(16, 30);
  endtask

  task automatic test_redirect();
    clear_image();
    build_mixed_stream(16);
    flash_image();
    collect_and_check(4, 100);
    @(posedge clk);
    out_ready   <= 1'b0;
    redirect    <= 1'b1;
    redirect_pc <= 32'd6; // entry boundary in the stream
    @(posedge clk);
    redirect <= 1'b0;
    model_pc = 32'd6;
    collect_and_check(8, 100);
  endtask

  // short image, the rest of memory must read back as zero
  task automatic test_reflash();
    clear_image();
    put_word(32'h02A00293);
    put_half(16'h12F5);
    put_half(16'h8426);
    flash_image();
    collect_and_check(8, 100);
  endtask

  initial begin
    void'($urandom(96));
    rst         = 1'b1;
    flash       = 1'b1; // keeps fetch halted until the first image is in
    uart_valid  = 1'b0;
    uart_data   = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    out_ready   = 1'b0;
    model_pc    = '0;
    image_len   = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_plain_program();
    test_compressed_mix();
    test_back_pressure();
    test_redirect();
    test_reflash();
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: build.f
+incdir+dv
src/rv_isa_pkg.sv
src/fetch_cfg_pkg.sv
src/fetch_if.sv
src/flash_loader.sv
src/program_memory.sv
src/rvc_expander.sv
src/fetch_unit.sv
src/instr_queue.sv
src/issue_port.sv
src/fetch_top.sv
dv/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - src/rv_isa_pkg.sv
  - src/fetch_cfg_pkg.sv
  - src/fetch_if.sv
  - src/flash_loader.sv
  - src/program_memory.sv
  - src/rvc_expander.sv
  - src/fetch_unit.sv
  - src/instr_queue.sv
  - src/issue_port.sv
  - src/fetch_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_fetch_top.sv
